/* rtl/rf_macros.svh */
// sizing macros for the register file and operand pipeline, included by every RTL file
`ifndef RF_MACROS_SVH
`define RF_MACROS_SVH

// operand width in bits
`define RF_WIDTH 32

// register count and matching address width
`define RF_ELS 32
`define RF_ADDR_W 5

// instruction tag carried alongside the operands
`define OPR_TAG_W 4

`endif

/* rtl/rf_pkg.sv */
// register file types shared by the storage array, the wrapper and the pipeline
`include "rf_macros.svh"

package rf_pkg;

    // ==============================
    // register file types
    // ==============================

    // register number
    typedef logic [`RF_ADDR_W-1:0] reg_addr_t;

    // register value
    typedef logic [`RF_WIDTH-1:0] reg_data_t;

endpackage

/* rtl/pipe_pkg.sv */
// pipeline types for the issue request that enters the operand read stage
`include "rf_macros.svh"

package pipe_pkg;

    // ==============================
    // issue side types
    // ==============================

    // tag that follows an instruction to its operands
    typedef logic [`OPR_TAG_W-1:0] tag_t;

    // one issue request, two sources and a tag
    typedef struct packed {
        rf_pkg::reg_addr_t rs1;
        rf_pkg::reg_addr_t rs2;
        tag_t              tag;
    } issue_req_t;

endpackage

/* rtl/rf_read_if.sv */
// both read ports of the register file, used between the operand stage and the wrapper
`timescale 1ns/1ps
`include "rf_macros.svh"

interface rf_read_if;

    // port 0
    logic                  r0_v;
    logic [`RF_ADDR_W-1:0] r0_addr;
    logic [`RF_WIDTH-1:0]  r0_data;

    // port 1
    logic                  r1_v;
    logic [`RF_ADDR_W-1:0] r1_addr;
    logic [`RF_WIDTH-1:0]  r1_data;

    // data follows a valid by one cycle, then holds
    modport requester (
        output r0_v, r0_addr, r1_v, r1_addr,
        input  r0_data, r1_data
    );

    modport file (
        input  r0_v, r0_addr, r1_v, r1_addr,
        output r0_data, r1_data
    );

endinterface

/* rtl/rf_mem_2r1w_sync.sv */
// two-read one-write register storage with registered read data, used inside the bypass wrapper
`timescale 1ns/1ps
`include "rf_macros.svh"

module rf_mem_2r1w_sync (
    input  logic              clk_i,
    input  logic              reset_i,

    input  logic              w_v_i,
    input  rf_pkg::reg_addr_t w_addr_i,
    input  rf_pkg::reg_data_t w_data_i,

    input  logic              r0_v_i,
    input  rf_pkg::reg_addr_t r0_addr_i,
    output rf_pkg::reg_data_t r0_data_o,

    input  logic              r1_v_i,
    input  rf_pkg::reg_addr_t r1_addr_i,
    output rf_pkg::reg_data_t r1_data_o
);

    import rf_pkg::*;

    reg_data_t mem [`RF_ELS];

    // write port
    always_ff @(posedge clk_i) begin
        if (w_v_i) begin
            mem[w_addr_i] <= w_data_i;
        end
    end

    // ==============================
    // read ports
    // ==============================

    // old contents on a same-address write, the wrapper covers that case
    always_ff @(posedge clk_i) begin
        if (r0_v_i) begin
            r0_data_o <= mem[r0_addr_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (r1_v_i) begin
            r1_data_o <= mem[r1_addr_i];
        end
    end

    // writes must land inside the array
    a_w_addr_range: assert property (
        @(posedge clk_i) disable iff (reset_i)
        w_v_i |-> (w_addr_i < `RF_ELS)
    ) else $error("write address %0d outside register file", w_addr_i);

endmodule

/* rtl/rf_bypass_wrapper.sv */
// register file wrapper with write-through bypass and stall hold, serving the operand stage
`timescale 1ns/1ps
`include "rf_macros.svh"

module rf_bypass_wrapper (
    input  logic              clk_i,
    input  logic              reset_i,

    input  logic              w_v_i,
    input  rf_pkg::reg_addr_t w_addr_i,
    input  rf_pkg::reg_data_t w_data_i,

    rf_read_if.file           rd
);

    import rf_pkg::*;

    // ==============================
    // same-cycle write and read
    // ==============================

    logic r0_bypass;
    logic r1_bypass;
    logic r0_mem_v;
    logic r1_mem_v;

    assign r0_bypass = w_v_i & rd.r0_v & (w_addr_i == rd.r0_addr);
    assign r1_bypass = w_v_i & rd.r1_v & (w_addr_i == rd.r1_addr);

    // no array read when the write data is returned instead
    assign r0_mem_v = rd.r0_v & ~r0_bypass;
    assign r1_mem_v = rd.r1_v & ~r1_bypass;

    reg_data_t r0_mem_data;
    reg_data_t r1_mem_data;

    rf_mem_2r1w_sync rf_mem_inst (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .w_v_i     (w_v_i),
        .w_addr_i  (w_addr_i),
        .w_data_i  (w_data_i),
        .r0_v_i    (r0_mem_v),
        .r0_addr_i (rd.r0_addr),
        .r0_data_o (r0_mem_data),
        .r1_v_i    (r1_mem_v),
        .r1_addr_i (rd.r1_addr),
        .r1_data_o (r1_mem_data)
    );

    logic      r0_bypass_r;
    logic      r1_bypass_r;
    logic      r0_v_r;
    logic      r1_v_r;
    reg_data_t w_data_r;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            r0_bypass_r <= 1'b0;
            r1_bypass_r <= 1'b0;
            r0_v_r      <= 1'b0;
            r1_v_r      <= 1'b0;
            w_data_r    <= '0;
        end else begin
            r0_bypass_r <= r0_bypass;
            r1_bypass_r <= r1_bypass;
            r0_v_r      <= rd.r0_v;
            r1_v_r      <= rd.r1_v;
            if (w_v_i) begin
                w_data_r <= w_data_i;
            end
        end
    end

    // ==============================
    // hold and late-write fold
    // ==============================

    reg_addr_t r0_addr_r;
    reg_addr_t r1_addr_r;

    always_ff @(posedge clk_i) begin
        if (rd.r0_v) begin
            r0_addr_r <= rd.r0_addr;
        end
        if (rd.r1_v) begin
            r1_addr_r <= rd.r1_addr;
        end
    end

    // write in the first output cycle to the address just read
    logic r0_fold;
    logic r1_fold;

    assign r0_fold = r0_v_r & w_v_i & (w_addr_i == r0_addr_r);
    assign r1_fold = r1_v_r & w_v_i & (w_addr_i == r1_addr_r);

    reg_data_t r0_fresh;
    reg_data_t r1_fresh;
    reg_data_t r0_hold_r;
    reg_data_t r1_hold_r;
    reg_data_t r0_data;
    reg_data_t r1_data;

    assign r0_fresh = r0_bypass_r ? w_data_r : r0_mem_data;
    assign r1_fresh = r1_bypass_r ? w_data_r : r1_mem_data;

    assign r0_data = !r0_v_r ? r0_hold_r : (r0_fold ? w_data_i : r0_fresh);
    assign r1_data = !r1_v_r ? r1_hold_r : (r1_fold ? w_data_i : r1_fresh);

    // hold tracks the output, so the folded value survives a stall
    always_ff @(posedge clk_i) begin
        r0_hold_r <= r0_data;
        r1_hold_r <= r1_data;
    end

    assign rd.r0_data = r0_data;
    assign rd.r1_data = r1_data;

    // requester must present clean addresses with its valids
    a_rd_addr_known: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (rd.r0_v |-> !$isunknown(rd.r0_addr)) and (rd.r1_v |-> !$isunknown(rd.r1_addr))
    ) else $error("read address has unknown bits while valid");

endmodule

/* rtl/operand_read_stage.sv */
// operand read stage that accepts issue requests and presents register operands downstream
`timescale 1ns/1ps
`include "rf_macros.svh"

module operand_read_stage (
    input  logic                 clk_i,
    input  logic                 reset_i,

    input  logic                 issue_v_i,
    input  pipe_pkg::issue_req_t issue_req_i,
    output logic                 issue_ready_o,

    output logic                 op_v_o,
    input  logic                 op_ready_i,
    output pipe_pkg::tag_t       op_tag_o,

    rf_read_if.requester         rd
);

    import rf_pkg::*;
    import pipe_pkg::*;

    // ==============================
    // issue handshake
    // ==============================

    logic accept;

    // free slot, or the current operands leave this cycle
    assign issue_ready_o = ~op_v_o | op_ready_i;
    assign accept        = issue_v_i & issue_ready_o;

    // read both sources in the accept cycle
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;

    assign rs1_addr = issue_req_i.rs1;
    assign rs2_addr = issue_req_i.rs2;

    assign rd.r0_v    = accept;
    assign rd.r0_addr = rs1_addr;
    assign rd.r1_v    = accept;
    assign rd.r1_addr = rs2_addr;

    // ==============================
    // output register
    // ==============================

    tag_t tag_r;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            op_v_o <= 1'b0;
        end else if (issue_ready_o) begin
            op_v_o <= issue_v_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            tag_r <= issue_req_i.tag;
        end
    end

    // operand data comes from the read interface at the top
    assign op_tag_o = tag_r;

    // stalled output keeps its valid and tag
    a_op_stable: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (op_v_o && !op_ready_i) |=> (op_v_o && $stable(op_tag_o))
    ) else $error("operand output changed while stalled");

endmodule

/* rtl/rf_operand_top.sv */
// top level of the operand fetch block, joining the read stage and the register file
`timescale 1ns/1ps
`include "rf_macros.svh"

module rf_operand_top (
    input  logic              clk_i,
    input  logic              reset_i,

    // issue side
    input  logic              issue_v_i,
    input  rf_pkg::reg_addr_t issue_rs1_i,
    input  rf_pkg::reg_addr_t issue_rs2_i,
    input  pipe_pkg::tag_t    issue_tag_i,
    output logic              issue_ready_o,

    // operand side
    output logic              op_v_o,
    input  logic              op_ready_i,
    output rf_pkg::reg_data_t op_rs1_data_o,
    output rf_pkg::reg_data_t op_rs2_data_o,
    output pipe_pkg::tag_t    op_tag_o,

    // writeback
    input  logic              wb_v_i,
    input  rf_pkg::reg_addr_t wb_addr_i,
    input  rf_pkg::reg_data_t wb_data_i
);

    import pipe_pkg::*;

    issue_req_t issue_req;

    assign issue_req = '{rs1: issue_rs1_i, rs2: issue_rs2_i, tag: issue_tag_i};

    rf_read_if rd_if ();

    operand_read_stage operand_read_stage_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .issue_v_i     (issue_v_i),
        .issue_req_i   (issue_req),
        .issue_ready_o (issue_ready_o),
        .op_v_o        (op_v_o),
        .op_ready_i    (op_ready_i),
        .op_tag_o      (op_tag_o),
        .rd            (rd_if.requester)
    );

    rf_bypass_wrapper rf_bypass_wrapper_inst (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .w_v_i    (wb_v_i),
        .w_addr_i (wb_addr_i),
        .w_data_i (wb_data_i),
        .rd       (rd_if.file)
    );

    // operands straight from the read ports
    assign op_rs1_data_o = rd_if.r0_data;
    assign op_rs2_data_o = rd_if.r1_data;

endmodule

/* verif/rf_operand_checker.sv */
// checker for the operand fetch block, watching the DUT ports and comparing against queued expectations
`timescale 1ns/1ps

module rf_operand_checker (
    input  logic              clk_i,
    input  logic              reset_i,

    // issue side with the expected operands of the line being issued
    input  logic              issue_v_i,
    input  logic              issue_ready_i,
    input  pipe_pkg::tag_t    issue_tag_i,
    input  rf_pkg::reg_data_t exp_rs1_i,
    input  rf_pkg::reg_data_t exp_rs2_i,

    // operand side
    input  logic              op_v_i,
    input  logic              op_ready_i,
    input  rf_pkg::reg_data_t op_rs1_data_i,
    input  rf_pkg::reg_data_t op_rs2_data_i,
    input  pipe_pkg::tag_t    op_tag_i,

    output int                error_count_o,
    output int                check_count_o,
    output int                xfer_count_o
);

    import rf_pkg::*;
    import pipe_pkg::*;

    tag_t      exp_tag_q [$];
    reg_data_t exp_rs1_q [$];
    reg_data_t exp_rs2_q [$];

    // snapshot of a stalled output
    logic      stalled;
    reg_data_t held_rs1;
    reg_data_t held_rs2;
    tag_t      held_tag;

    // issue taken at the last edge
    logic      issued;

    initial begin
        error_count_o = 0;
        check_count_o = 0;
        xfer_count_o  = 0;
        stalled       = 1'b0;
        issued        = 1'b0;
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count_o = check_count_o + 1;
        if (actual !== expected) begin
            error_count_o = error_count_o + 1;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // ==============================
    // sampling in mid cycle
    // ==============================

    always @(negedge clk_i) begin
        if (reset_i) begin
            stalled = 1'b0;
            issued  = 1'b0;
        end else begin
            // operands follow an accepted issue by one cycle
            if (issued && !op_v_i) begin
                error_count_o = error_count_o + 1;
                $display("op_v_o stayed low in the cycle after an accepted issue");
            end

            // ready whenever the output slot is empty or draining
            compare_value("issue_ready_o", !op_v_i || op_ready_i, issue_ready_i);

            // a stalled output must come back unchanged
            if (stalled) begin
                if (!op_v_i) begin
                    error_count_o = error_count_o + 1;
                    $display("op_v_o dropped while the operands were stalled");
                end
                compare_value("op_rs1_data_o", held_rs1, op_rs1_data_i);
                compare_value("op_rs2_data_o", held_rs2, op_rs2_data_i);
                compare_value("op_tag_o", held_tag, op_tag_i);
            end
            stalled  = op_v_i & ~op_ready_i;
            held_rs1 = op_rs1_data_i;
            held_rs2 = op_rs2_data_i;
            held_tag = op_tag_i;

            if (op_v_i && op_ready_i) begin
                xfer_count_o = xfer_count_o + 1;
                if (exp_tag_q.size() == 0) begin
                    error_count_o = error_count_o + 1;
                    $display("operand transfer arrived with no issue waiting for it");
                end else begin
                    compare_value("op_tag_o", exp_tag_q.pop_front(), op_tag_i);
                    compare_value("op_rs1_data_o", exp_rs1_q.pop_front(), op_rs1_data_i);
                    compare_value("op_rs2_data_o", exp_rs2_q.pop_front(), op_rs2_data_i);
                end
            end

            // accepted issues queue their expected operands
            issued = issue_v_i & issue_ready_i;
            if (issue_v_i && issue_ready_i) begin
                exp_tag_q.push_back(issue_tag_i);
                exp_rs1_q.push_back(exp_rs1_i);
                exp_rs2_q.push_back(exp_rs2_i);
            end
        end
    end

endmodule

/* verif/rf_operand_tb.sv */
// testbench top for the operand fetch block, driving lines from the cases file into the DUT
`timescale 1ns/1ps
`include "rf_macros.svh"

module rf_operand_tb;

    import rf_pkg::*;
    import pipe_pkg::*;

    localparam int NUM_CASES       = 16;
    localparam int CASE_WORDS      = 8;
    localparam int FREE_RUN_FROM   = 10;
    localparam int WATCHDOG_CYCLES = NUM_CASES * 8 + 100;

    logic        clk_i;
    logic        reset_i;
    logic        issue_v_i;
    reg_addr_t   issue_rs1_i;
    reg_addr_t   issue_rs2_i;
    tag_t        issue_tag_i;
    logic        issue_ready_o;
    logic        op_v_o;
    logic        op_ready_i;
    reg_data_t   op_rs1_data_o;
    reg_data_t   op_rs2_data_o;
    tag_t        op_tag_o;
    logic        wb_v_i;
    reg_addr_t   wb_addr_i;
    reg_data_t   wb_data_i;
    reg_data_t   exp_rs1;
    reg_data_t   exp_rs2;

    logic [31:0] case_mem [0:NUM_CASES*CASE_WORDS-1];
    int          error_count;
    int          check_count;
    int          xfer_count;
    int          idx;

    rf_operand_top rf_operand_top_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .issue_v_i     (issue_v_i),
        .issue_rs1_i   (issue_rs1_i),
        .issue_rs2_i   (issue_rs2_i),
        .issue_tag_i   (issue_tag_i),
        .issue_ready_o (issue_ready_o),
        .op_v_o        (op_v_o),
        .op_ready_i    (op_ready_i),
        .op_rs1_data_o (op_rs1_data_o),
        .op_rs2_data_o (op_rs2_data_o),
        .op_tag_o      (op_tag_o),
        .wb_v_i        (wb_v_i),
        .wb_addr_i     (wb_addr_i),
        .wb_data_i     (wb_data_i)
    );

    rf_operand_checker rf_operand_checker_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .issue_v_i     (issue_v_i),
        .issue_ready_i (issue_ready_o),
        .issue_tag_i   (issue_tag_i),
        .exp_rs1_i     (exp_rs1),
        .exp_rs2_i     (exp_rs2),
        .op_v_i        (op_v_o),
        .op_ready_i    (op_ready_i),
        .op_rs1_data_i (op_rs1_data_o),
        .op_rs2_data_i (op_rs2_data_o),
        .op_tag_i      (op_tag_o),
        .error_count_o (error_count),
        .check_count_o (check_count),
        .xfer_count_o  (xfer_count)
    );

    initial begin
        clk_i = 1'b0;
    end

    always #20 clk_i = ~clk_i;

    // one cases line is a writeback plus an issue with its expected operands
    task automatic apply_case(input int line);
        int base;
        base        = line * CASE_WORDS;
        wb_v_i      = case_mem[base][0];
        wb_addr_i   = case_mem[base+1][`RF_ADDR_W-1:0];
        wb_data_i   = case_mem[base+2];
        issue_rs1_i = case_mem[base+3][`RF_ADDR_W-1:0];
        issue_rs2_i = case_mem[base+4][`RF_ADDR_W-1:0];
        issue_tag_i = case_mem[base+5][`OPR_TAG_W-1:0];
        exp_rs1     = case_mem[base+6];
        exp_rs2     = case_mem[base+7];
        issue_v_i   = 1'b1;
    endtask

    // random stalls early on and free running from FREE_RUN_FROM
    task automatic drive_ready(input int line);
        if (line >= FREE_RUN_FROM) begin
            op_ready_i = 1'b1;
        end else begin
            op_ready_i = (($urandom % 3) != 0);
        end
    endtask

    task automatic idle_inputs();
        issue_v_i = 1'b0;
        wb_v_i    = 1'b0;
    endtask

    // ==============================
    // stimulus
    // ==============================

    initial begin
        void'($urandom(32'hcb662326));
        reset_i     = 1'b1;
        issue_v_i   = 1'b0;
        issue_rs1_i = '0;
        issue_rs2_i = '0;
        issue_tag_i = '0;
        op_ready_i  = 1'b0;
        wb_v_i      = 1'b0;
        wb_addr_i   = '0;
        wb_data_i   = '0;
        exp_rs1     = '0;
        exp_rs2     = '0;
        $readmemh("verif/rf_operand_cases.txt", case_mem);

        repeat (4) @(posedge clk_i);
        #2;
        reset_i = 1'b0;

        // each line stays applied until the stage takes it
        for (idx = 0; idx < NUM_CASES; idx++) begin
            apply_case(idx);
            drive_ready(idx);
            @(negedge clk_i);
            while (!issue_ready_o) begin
                @(posedge clk_i);
                #2;
                drive_ready(idx);
                @(negedge clk_i);
            end
            @(posedge clk_i);
            #2;
        end
        idle_inputs();

        // drain the last operands
        while (xfer_count < NUM_CASES) begin
            drive_ready(NUM_CASES);
            @(posedge clk_i);
            #2;
        end

        $display("checks %0d, transfers %0d, errors %0d", check_count, xfer_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog sized from the number of lines
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout after %0d cycles with %0d of %0d operand sets received",
                 WATCHDOG_CYCLES, xfer_count, NUM_CASES);
        $display("checks %0d, transfers %0d, errors %0d", check_count, xfer_count, error_count);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+rtl
rtl/rf_pkg.sv
rtl/pipe_pkg.sv
rtl/rf_read_if.sv
rtl/rf_mem_2r1w_sync.sv
rtl/rf_bypass_wrapper.sv
rtl/operand_read_stage.sv
rtl/rf_operand_top.sv
verif/rf_operand_checker.sv
verif/rf_operand_tb.sv

/* verif/rf_operand_cases.txt */
// columns: wb_v wb_addr wb_data rs1 rs2 tag exp_rs1 exp_rs2 (hex)
// expected operands include the writes of this line and of the next one
1 01 11111111 01 01 0 11111111 11111111
1 02 22222222 01 02 1 11111111 22222222
1 03 33333333 02 01 2 22222222 11111111
1 04 44444444 03 05 3 33333333 55555555
1 05 55555555 04 04 4 a0a0a0a0 a0a0a0a0
1 04 a0a0a0a0 05 03 5 55555555 33333333
1 06 66666666 06 04 6 6a6a6a6a a0a0a0a0
1 06 6a6a6a6a 02 06 7 22222222 6a6a6a6a
1 07 77777777 07 01 8 77777777 11111111
0 00 00000000 03 07 9 3c3c3c3c 77777777
1 03 3c3c3c3c 03 03 a 3c3c3c3c 3c3c3c3c
1 01 1e1e1e1e 01 05 b 1e1e1e1e 5a5a5a5a
1 05 5a5a5a5a 04 06 c a0a0a0a0 6a6a6a6a
1 08 88888888 08 05 d 8f8f8f8f 5a5a5a5a
1 08 8f8f8f8f 07 08 e 77777777 8f8f8f8f
1 1f f0f0f0f0 1f 08 f f0f0f0f0 8f8f8f8f
